/* design/soc_cfg_pkg.sv */
//----------------------------------------------------------------------
// board and memory map constants for the memory subsystem
// FLASH_TRANSFER_BYTE_COUNT must be a multiple of LINE_BYTES
// STARTUP_WAIT_CYCLES is the short simulation value and must be 2 or more
//----------------------------------------------------------------------
package soc_cfg_pkg;

  //--------------------------------------------------------------------
  // burst RAM geometry
  //--------------------------------------------------------------------

  localparam int RAM_ADDRESS_BITWIDTH = 21;  // byte address into PSRAM
  localparam int LINE_BYTES = 8;             // one burst = one line
  localparam int LINE_BITS = LINE_BYTES * 8;
  localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);  // byte within line

  //--------------------------------------------------------------------
  // boot loader
  //--------------------------------------------------------------------

  // idle cycles after reset, lets flash wake up
  localparam int STARTUP_WAIT_CYCLES = 16;
  localparam int STARTUP_WAIT_BITWIDTH = $clog2(STARTUP_WAIT_CYCLES);

  // image location in flash, copied to RAM address 0
  localparam logic [23:0] FLASH_TRANSFER_FROM_ADDRESS = 24'h00_1000;
  localparam int FLASH_TRANSFER_BYTE_COUNT = 64;

  // plain serial read, no dummy cycles
  localparam logic [7:0] FLASH_READ_CMD = 8'h03;

endpackage

/* design/mem_types_pkg.sv */
//----------------------------------------------------------------------
// types of the core load/store port and the 64 bit burst RAM port
// burst addresses are byte addresses, always line aligned
//----------------------------------------------------------------------
package mem_types_pkg;

  import soc_cfg_pkg::*;

  //--------------------------------------------------------------------
  // core side opcodes
  //--------------------------------------------------------------------

  // bit 2 set means zero extend
  typedef enum logic [2:0] {
    rd_none = 3'b000,
    rd_lb   = 3'b001,
    rd_lh   = 3'b010,
    rd_lw   = 3'b011,
    rd_lbu  = 3'b101,
    rd_lhu  = 3'b110
  } read_type_e;

  typedef enum logic [1:0] {
    wr_none = 2'b00,
    wr_sb   = 2'b01,
    wr_sh   = 2'b10,
    wr_sw   = 2'b11
  } write_type_e;

  // request sampled with the enable strobe
  typedef struct packed {
    read_type_e  read_type;
    write_type_e write_type;
    logic [31:0] address;   // byte address
    logic [31:0] data_in;   // store data, low bytes used
  } core_req_t;

  //--------------------------------------------------------------------
  // burst RAM side
  //--------------------------------------------------------------------

  typedef enum logic {
    br_read  = 1'b0,
    br_write = 1'b1
  } br_cmd_e;

  typedef struct packed {
    br_cmd_e                         cmd;
    logic                            cmd_en;   // one cycle strobe
    logic [RAM_ADDRESS_BITWIDTH-1:0] addr;     // line aligned
    logic [LINE_BITS-1:0]            wr_data;  // whole line, no mask
  } br_req_t;

  typedef struct packed {
    logic [LINE_BITS-1:0] rd_data;
    logic                 rd_data_valid;  // one pulse per read
  } br_rsp_t;

endpackage

/* design/flash_loader.sv */
//----------------------------------------------------------------------
// copies FLASH_TRANSFER_BYTE_COUNT bytes from SPI flash to RAM address 0
// SPI mode 0 at clk/2, miso sampled as flash_clk falls
// flash clock pauses while a line write waits for the grant
//----------------------------------------------------------------------
`timescale 1ns/1ps

module flash_loader
  import soc_cfg_pkg::*, mem_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  output logic    flash_cs_n,
  output logic    flash_clk,
  output logic    flash_mosi,
  input  logic    flash_miso,
  output br_req_t req,
  input  logic    gnt,
  output logic    load_done
);

  typedef enum logic [2:0] {st_wait, st_cmd, st_addr, st_data, st_write, st_done} state_e;

  state_e                           state;
  logic [STARTUP_WAIT_BITWIDTH-1:0] wait_cnt;
  logic [31:0]                      cmd_sr;   // opcode then address, msb first
  logic [5:0]                       bit_cnt;  // up to 64 bits per line
  logic [6:0]                       byte_sr;  // partial byte from miso
  logic [LINE_BITS-1:0]             line_q;   // assembled line
  logic [RAM_ADDRESS_BITWIDTH-1:0]  wr_addr;

  assign flash_mosi = cmd_sr[31];
  assign load_done  = (state == st_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= st_wait;
      wait_cnt   <= '0;
      cmd_sr     <= {FLASH_READ_CMD, FLASH_TRANSFER_FROM_ADDRESS};
      bit_cnt    <= '0;
      flash_cs_n <= 1'b1;
      flash_clk  <= 1'b0;
      wr_addr    <= '0;
    end else begin
      case (state)
        st_wait: begin
          wait_cnt <= wait_cnt + 1'b1;
          if (wait_cnt == STARTUP_WAIT_BITWIDTH'(STARTUP_WAIT_CYCLES - 1)) begin
            flash_cs_n <= 1'b0;  // held low until the last byte
            state      <= st_cmd;
          end
        end
        st_cmd, st_addr, st_data: begin
          flash_clk <= ~flash_clk;
          if (flash_clk) begin  // falling edge, next bit
            cmd_sr  <= cmd_sr << 1;
            bit_cnt <= bit_cnt + 1'b1;
            if (state == st_cmd && bit_cnt == 6'd7) begin
              bit_cnt <= '0;
              state   <= st_addr;
            end
            if (state == st_addr && bit_cnt == 6'd23) begin
              bit_cnt <= '0;
              state   <= st_data;
            end
            if (state == st_data && bit_cnt == 6'(LINE_BITS - 1)) begin
              state <= st_write;  // line full
            end
          end
        end
        st_write: begin
          if (gnt) begin
            wr_addr <= wr_addr + RAM_ADDRESS_BITWIDTH'(LINE_BYTES);
            if (wr_addr == RAM_ADDRESS_BITWIDTH'(FLASH_TRANSFER_BYTE_COUNT - LINE_BYTES)) begin
              flash_cs_n <= 1'b1;
              state      <= st_done;
            end else begin
              state <= st_data;  // bit_cnt wrapped to 0 already
            end
          end
        end
        default: state <= st_done;  // st_done is terminal
      endcase
    end
  end

  // miso shift and line assembly
  always_ff @(posedge clk) begin
    if (state == st_data && flash_clk) begin
      byte_sr <= {byte_sr[5:0], flash_miso};
      if (bit_cnt[2:0] == 3'd7) begin
        line_q <= {byte_sr, flash_miso, line_q[LINE_BITS-1:8]};  // first byte ends lowest
      end
    end
  end

  // write request, retried until granted
  always_comb begin
    req.cmd     = br_write;
    req.cmd_en  = (state == st_write);
    req.addr    = wr_addr;
    req.wr_data = line_q;
  end

endmodule

/* design/ramio_port.sv */
//----------------------------------------------------------------------
// core load/store engine on top of the 64 bit burst RAM port
// every access reads its line, stores merge and write the line back
// requests must not cross a line, halfwords and words naturally aligned
//----------------------------------------------------------------------
`timescale 1ns/1ps

module ramio_port
  import soc_cfg_pkg::*, mem_types_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        enable,
  input  core_req_t   core_req,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic        busy,
  output br_req_t     req,
  input  br_rsp_t     rsp,
  input  logic        gnt
);

  typedef enum logic [1:0] {st_idle, st_read, st_wait, st_write} state_e;

  state_e                      state;
  core_req_t                   req_q;     // latched at enable
  logic [LINE_BITS-1:0]        line_q;    // merged line for write back
  logic [LINE_OFFSET_BITS-1:0] offset;
  logic [LINE_BITS-1:0]        shifted;   // addressed byte moved to bit 0
  logic [LINE_BITS-1:0]        merged;
  logic [31:0]                 load_value;
  logic                        is_store;

  assign offset   = req_q.address[LINE_OFFSET_BITS-1:0];
  assign is_store = (req_q.write_type != wr_none);
  assign shifted  = rsp.rd_data >> {offset, 3'b000};
  assign busy     = (state != st_idle);

  //--------------------------------------------------------------------
  // load extraction and store merge, both from the returning line
  //--------------------------------------------------------------------

  always_comb begin
    case (req_q.read_type)
      rd_lb:   load_value = {{24{shifted[7]}}, shifted[7:0]};
      rd_lbu:  load_value = {24'b0, shifted[7:0]};
      rd_lh:   load_value = {{16{shifted[15]}}, shifted[15:0]};
      rd_lhu:  load_value = {16'b0, shifted[15:0]};
      default: load_value = shifted[31:0];  // lw
    endcase
  end

  always_comb begin
    merged = rsp.rd_data;
    case (req_q.write_type)
      wr_sb:   merged[{offset, 3'b000} +: 8]  = req_q.data_in[7:0];
      wr_sh:   merged[{offset, 3'b000} +: 16] = req_q.data_in[15:0];
      wr_sw:   merged[{offset, 3'b000} +: 32] = req_q.data_in;
      default: ;  // load, line untouched
    endcase
  end

  //--------------------------------------------------------------------
  // control FSM
  //--------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= st_idle;
      data_out_ready <= 1'b0;
    end else begin
      data_out_ready <= 1'b0;  // single cycle pulse
      case (state)
        st_idle:  if (enable) state <= st_read;
        st_read:  if (gnt) state <= st_wait;  // lost arbitration, ask again
        st_wait: begin
          if (rsp.rd_data_valid) begin
            if (is_store) begin
              state <= st_write;
            end else begin
              state          <= st_idle;
              data_out_ready <= 1'b1;  // busy drops with it
            end
          end
        end
        st_write: if (gnt) state <= st_idle;  // write done at grant
        default:  state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && enable) begin
      req_q <= core_req;
    end
    if (state == st_wait && rsp.rd_data_valid) begin
      line_q   <= merged;
      data_out <= load_value;
    end
  end

  // same line address for the read and the write back
  always_comb begin
    req.cmd     = (state == st_write) ? br_write : br_read;
    req.cmd_en  = (state == st_read) || (state == st_write);
    req.addr    = {req_q.address[RAM_ADDRESS_BITWIDTH-1:LINE_OFFSET_BITS],
                   {LINE_OFFSET_BITS{1'b0}}};
    req.wr_data = line_q;
  end

  //--------------------------------------------------------------------
  // protocol checks on the core side
  //--------------------------------------------------------------------

  a_no_enable_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !enable)
    else $error("enable while busy");

  a_half_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    enable && (core_req.read_type inside {rd_lh, rd_lhu} || core_req.write_type == wr_sh)
    |-> !core_req.address[0])
    else $error("misaligned halfword access");

  a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    enable && (core_req.read_type == rd_lw || core_req.write_type == wr_sw)
    |-> core_req.address[1:0] == 2'b00)
    else $error("misaligned word access");

endmodule

/* design/burst_arbiter.sv */
//----------------------------------------------------------------------
// two way arbiter in front of the burst RAM port, loader has priority
// a granted read locks the port until its rd_data_valid
// a requester that loses must hold its request until granted
//----------------------------------------------------------------------
`timescale 1ns/1ps

module burst_arbiter
  import mem_types_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  br_req_t loader_req,
  input  br_req_t core_req,
  output logic    loader_gnt,
  output logic    core_gnt,
  output br_rsp_t loader_rsp,
  output br_rsp_t core_rsp,
  output br_req_t br_req,
  input  br_rsp_t br_rsp
);

  logic lock;        // read in flight
  logic owner_core;  // who issued that read

  // fixed priority, nothing granted while locked
  assign loader_gnt = !lock && loader_req.cmd_en;
  assign core_gnt   = !lock && core_req.cmd_en && !loader_req.cmd_en;

  always_comb begin
    br_req        = core_gnt ? core_req : loader_req;
    br_req.cmd_en = loader_gnt || core_gnt;  // losing strobe never leaks out
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock       <= 1'b0;
      owner_core <= 1'b0;
    end else if (br_req.cmd_en && br_req.cmd == br_read) begin
      lock       <= 1'b1;
      owner_core <= core_gnt;
    end else if (br_rsp.rd_data_valid) begin
      lock <= 1'b0;
    end
  end

  // data fans out, only the owner sees valid
  always_comb begin
    loader_rsp.rd_data       = br_rsp.rd_data;
    loader_rsp.rd_data_valid = br_rsp.rd_data_valid && lock && !owner_core;
    core_rsp.rd_data         = br_rsp.rd_data;
    core_rsp.rd_data_valid   = br_rsp.rd_data_valid && lock && owner_core;
  end

  a_rsp_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
    br_rsp.rd_data_valid |-> lock)
    else $error("rd_data_valid with no read outstanding");

  // back pressure contract for the core port
  a_core_holds_request: assert property (@(posedge clk) disable iff (!rst_n)
    core_req.cmd_en && !core_gnt |=> core_req.cmd_en && $stable(core_req.addr))
    else $error("core request dropped before grant");

endmodule

/* design/mem_top.sv */
//----------------------------------------------------------------------
// memory side top: boot loader, core load/store port, burst arbiter
// PSRAM controller sits outside on br_req/br_rsp
// core requests are legal before load_done, loads see partial image
//----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_top
  import mem_types_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // core port
  input  logic        enable,
  input  core_req_t   core_req,
  output logic [31:0] data_out,
  output logic        data_out_ready,
  output logic        busy,
  output logic        load_done,
  // SPI flash
  output logic        flash_cs_n,
  output logic        flash_clk,
  output logic        flash_mosi,
  input  logic        flash_miso,
  // burst RAM
  output br_req_t     br_req,
  input  br_rsp_t     br_rsp
);

  br_req_t loader_req;
  br_req_t core_br_req;
  br_rsp_t core_br_rsp;
  logic    loader_gnt;
  logic    core_gnt;

  flash_loader flash_loader_inst (
    .clk,
    .rst_n,
    .flash_cs_n,
    .flash_clk,
    .flash_mosi,
    .flash_miso,
    .req      (loader_req),
    .gnt      (loader_gnt),
    .load_done
  );

  ramio_port ramio_port_inst (
    .clk,
    .rst_n,
    .enable,
    .core_req,
    .data_out,
    .data_out_ready,
    .busy,
    .req (core_br_req),
    .rsp (core_br_rsp),
    .gnt (core_gnt)
  );

  burst_arbiter burst_arbiter_inst (
    .clk,
    .rst_n,
    .loader_req,
    .core_req   (core_br_req),
    .loader_gnt,
    .core_gnt,
    .loader_rsp (),  // loader only writes
    .core_rsp   (core_br_rsp),
    .br_req,
    .br_rsp
  );

endmodule

/* verif/tb_models.sv */
//----------------------------------------------------------------------
// behavioural SPI flash (mode 0, read command only) and burst RAM
// flash image is loaded by the testbench, 8 KB, upper address bits ignored
// RAM model covers the low 4 KB, filled with an address pattern in reset
// read latency is sampled with each read cmd_en and must be 2 or more
//----------------------------------------------------------------------
`timescale 1ns/1ps

module flash_model (
  input  logic cs_n,
  input  logic sck,
  input  logic mosi,
  output logic miso
);

  localparam int IMAGE_BYTES = 8192;
  localparam logic [7:0] READ_CMD = 8'h03;  // plain serial read

  logic [7:0]  image [IMAGE_BYTES];  // written by the testbench
  logic [31:0] cmd_sr;               // opcode and 24 bit address
  logic [5:0]  rise_cnt;             // header bits seen so far
  logic [12:0] rd_addr;
  logic [2:0]  bit_idx;
  logic        streaming;

  // header shifts in on rising sck
  always @(posedge sck or posedge cs_n) begin
    if (cs_n) begin
      rise_cnt <= '0;
    end else if (rise_cnt < 6'd32) begin
      cmd_sr   <= {cmd_sr[30:0], mosi};
      rise_cnt <= rise_cnt + 6'd1;
    end
  end

  // data goes out msb first on falling sck, address auto increments
  // any other opcode leaves miso low
  always @(negedge sck or posedge cs_n) begin
    if (cs_n) begin
      streaming <= 1'b0;
      miso      <= 1'b0;
    end else if (rise_cnt == 6'd32 && cmd_sr[31:24] == READ_CMD) begin
      if (!streaming) begin  // falling edge after last address bit
        streaming <= 1'b1;
        rd_addr   <= cmd_sr[12:0];
        bit_idx   <= 3'd6;
        miso      <= image[cmd_sr[12:0]][7];
      end else begin
        miso    <= image[rd_addr][bit_idx];
        bit_idx <= bit_idx - 3'd1;
        if (bit_idx == 3'd0) begin
          rd_addr <= rd_addr + 13'd1;  // next byte
        end
      end
    end
  end

endmodule

module burst_ram_model
  import soc_cfg_pkg::*, mem_types_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  br_req_t    br_req,
  output br_rsp_t    br_rsp,
  input  logic [2:0] latency  // cmd_en to rd_data_valid, in cycles
);

  localparam int RAM_LINES = 512;

  logic [LINE_BITS-1:0] mem [RAM_LINES];
  logic [8:0]           line_idx;
  logic [8:0]           rd_idx;
  logic [2:0]           lat_cnt;
  logic                 pending;  // read in flight

  assign line_idx = br_req.addr[11:3];

  // every byte depends on its whole 12 bit address
  function automatic logic [LINE_BITS-1:0] fill_line(input logic [8:0] idx);
    logic [LINE_BITS-1:0] v;
    logic [11:0]          a;
    for (int k = 0; k < LINE_BYTES; k++) begin
      a            = {idx, 3'(k)};
      v[8*k +: 8] = a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3C;
    end
    return v;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
      lat_cnt <= '0;
      rd_idx  <= '0;
      br_rsp  <= '0;
      for (int i = 0; i < RAM_LINES; i++) begin
        mem[i] <= fill_line(9'(i));
      end
    end else begin
      br_rsp.rd_data_valid <= 1'b0;
      if (br_req.cmd_en && br_req.cmd == br_write) begin
        mem[line_idx] <= br_req.wr_data;  // whole line, done at cmd_en
      end
      if (br_req.cmd_en && br_req.cmd == br_read) begin
        pending <= 1'b1;
        lat_cnt <= latency - 3'd1;
        rd_idx  <= line_idx;
      end else if (pending) begin
        lat_cnt <= lat_cnt - 3'd1;
        if (lat_cnt == 3'd1) begin
          pending <= 1'b0;
          br_rsp  <= {mem[rd_idx], 1'b1};
        end
      end
    end
  end

endmodule

/* verif/mem_top_tb.sv */
//----------------------------------------------------------------------
// testbench for mem_top with the flash and burst RAM models
// checks are concurrent assertions on the DUT outputs
// core accesses stay inside the 4 KB window of the RAM model
//----------------------------------------------------------------------
`timescale 1ns/1ps

module mem_top_tb
  import soc_cfg_pkg::*, mem_types_pkg::*;
();

  localparam int RAM_BYTES         = 4096;
  localparam int FLASH_IMAGE_BYTES = 8192;
  localparam int LOAD_BITS         = 32 + FLASH_TRANSFER_BYTE_COUNT * 8;
  localparam int ACCESS_COUNT      = 132;  // accesses after the copy, with margin
  localparam int WATCHDOG_CYCLES   = LOAD_BITS * 2 + ACCESS_COUNT * 12
                                     + STARTUP_WAIT_CYCLES + 5;
  localparam int ACCESS_TIMEOUT    = 40;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        enable;
  core_req_t   core_req;
  logic [31:0] data_out;
  logic        data_out_ready;
  logic        busy;
  logic        load_done;
  logic        flash_cs_n;
  logic        flash_clk;
  logic        flash_mosi;
  logic        flash_miso;
  br_req_t     br_req;
  br_rsp_t     br_rsp;
  logic [2:0]  ram_latency = 3'd2;

  logic [7:0]  sb_mem [RAM_BYTES];  // scoreboard, mirrors RAM bytes
  logic [15:0] stim_lfsr = 16'd40757;
  logic [15:0] lat_lfsr  = 16'd40757;
  logic [31:0] exp_data;            // value the pending load must return
  logic        op_is_read;
  logic        line0_written;
  string       test_name = "reset";
  int          errors = 0;
  int          errs_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  always #2 clk = ~clk;  // 4 ns period

  mem_top mem_top_inst (.*);

  flash_model flash_model_inst (
    .cs_n (flash_cs_n),
    .sck  (flash_clk),
    .mosi (flash_mosi),
    .miso (flash_miso)
  );

  burst_ram_model burst_ram_model_inst (
    .clk,
    .rst_n,
    .br_req,
    .br_rsp,
    .latency (ram_latency)
  );

  //--------------------------------------------------------------------
  // random numbers and expected values
  //--------------------------------------------------------------------

  // Galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);  // one step per bit
      v         = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [2:0] rand_latency();
    logic [2:0] v;
    v = '0;
    for (int i = 0; i < 3; i++) begin
      lat_lfsr = lfsr_next(lat_lfsr);
      v        = {v[1:0], lat_lfsr[0]};
    end
    return 3'd2 + (v % 3'd5);  // 2 to 6 cycles
  endfunction

  // little endian bytes, extension per opcode
  function automatic logic [31:0] expected_load(input read_type_e rt, input int a);
    logic [31:0] w;
    w = {sb_mem[a + 3], sb_mem[a + 2], sb_mem[a + 1], sb_mem[a]};
    case (rt)
      rd_lb:   return {{24{w[7]}}, w[7:0]};
      rd_lbu:  return {24'h0, w[7:0]};
      rd_lh:   return {{16{w[15]}}, w[15:0]};
      rd_lhu:  return {16'h0, w[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic store_scoreboard(input write_type_e wt, input int a, input logic [31:0] d);
    int n;
    n = (wt == wr_sb) ? 1 : (wt == wr_sh) ? 2 : 4;
    for (int i = 0; i < n; i++) begin
      sb_mem[a + i] = d[8*i +: 8];
    end
  endtask

  // fresh latency for every read the RAM model sees
  always @(negedge clk) begin
    if (br_req.cmd_en && br_req.cmd == br_read) begin
      ram_latency = rand_latency();
    end
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line0_written <= 1'b0;
    end else if (br_req.cmd_en && br_req.cmd == br_write && br_req.addr == '0) begin
      line0_written <= 1'b1;  // loader's first line is in RAM
    end
  end

  //--------------------------------------------------------------------
  // checks
  //--------------------------------------------------------------------

  task automatic flag_failure(input string what);
    $display("%s: %s", test_name, what);
    errors++;
  endtask

  a_reset_values: assert property (@(posedge clk) $rose(rst_n) |->
    !busy && !data_out_ready && !load_done && !br_req.cmd_en && flash_cs_n)
    else flag_failure("outputs not idle after reset");

  a_load_data: assert property (@(posedge clk) disable iff (!rst_n)
    data_out_ready |-> data_out == exp_data)
    else begin
      $display("** Error %s: expected %h actual %h", test_name, exp_data, data_out);
      errors++;
    end

  a_busy_after_enable: assert property (@(posedge clk) disable iff (!rst_n)
    enable |=> busy)
    else flag_failure("busy did not rise after enable");

  // ready goes with busy falling, and only for reads
  a_ready_at_end: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> data_out_ready == op_is_read)
    else flag_failure("data_out_ready wrong at end of access");

  a_ready_only_at_end: assert property (@(posedge clk) disable iff (!rst_n)
    data_out_ready |-> $fell(busy))
    else flag_failure("data_out_ready outside end of access");

  a_done_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    load_done |=> load_done)
    else flag_failure("load_done dropped");

  //--------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------

  task automatic core_access(input read_type_e rt, input write_type_e wt, input int a,
                             input logic [31:0] d);
    int cycles;
    @(negedge clk);
    core_req   = '{read_type: rt, write_type: wt, address: 32'(a), data_in: d};
    op_is_read = (wt == wr_none);
    exp_data   = expected_load(rt, a);
    enable     = 1'b1;
    @(negedge clk);
    enable = 1'b0;
    cycles = 0;
    while (busy && cycles < ACCESS_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (busy) begin
      flag_failure($sformatf("access to %h never finished", a));
    end else if (!op_is_read) begin
      store_scoreboard(wt, a, d);
    end
    @(negedge clk);  // end of access sampled at the posedge in between
  endtask

  task automatic store_and_check_line(input write_type_e wt, input int a,
                                      input logic [31:0] d);
    int line_base;
    line_base = a & ~(LINE_BYTES - 1);
    core_access(rd_none, wt, a, d);
    core_access(rd_lw, wr_none, line_base, 0);  // whole line back
    core_access(rd_lw, wr_none, line_base + 4, 0);
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    errs_start = errors;
  endtask

  task automatic finish_test();
    tests_run++;
    if (errors != errs_start) begin
      tests_failed++;
    end
    $display("test %s: %0d errors", test_name, errors - errs_start);
  endtask

  task automatic end_run();
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    flag_failure($sformatf("watchdog fired after %0d cycles", WATCHDOG_CYCLES));
    end_run();
  end

  initial begin
    int          cycles;
    int          base;
    int          op;
    int          a;
    logic [31:0] d;
    rst_n    = 1'b0;
    enable   = 1'b0;
    core_req = '0;
    for (int i = 0; i < FLASH_IMAGE_BYTES; i++) begin
      flash_model_inst.image[i] = 8'(rand_bits(8));
    end
    start_test("reset");
    repeat (5) @(posedge clk);
    for (int i = 0; i < RAM_BYTES; i++) begin
      sb_mem[i] = burst_ram_model_inst.mem[i / 8][8 * (i % 8) +: 8];
    end
    for (int i = 0; i < FLASH_TRANSFER_BYTE_COUNT; i++) begin
      sb_mem[i] = flash_model_inst.image[int'(FLASH_TRANSFER_FROM_ADDRESS) + i];
    end
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    finish_test();

    // core traffic while the loader still owns most of the bus
    start_test("arbitration");
    cycles = 0;
    while (!line0_written && cycles < LOAD_BITS * 2) begin
      @(negedge clk);
      cycles++;
    end
    a_line0_seen: assert (line0_written) else flag_failure("loader never wrote line 0");
    a_still_loading: assert (!load_done) else flag_failure("copy ended before test");
    // keeps meeting the remaining line writes of the loader
    while (!load_done) begin
      core_access(rd_lw, wr_none, 0, 0);
      core_access(rd_lw, wr_none, 4, 0);
      core_access(rd_none, wr_sw, 32'h200, rand_bits(32));
      core_access(rd_lw, wr_none, 32'h200, 0);
    end
    finish_test();

    start_test("boot_copy");
    cycles = 0;
    while (!load_done && cycles < WATCHDOG_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    a_load_finished: assert (load_done) else flag_failure("load_done never rose");
    for (int i = 0; i < FLASH_TRANSFER_BYTE_COUNT; i += 4) begin
      core_access(rd_lw, wr_none, i, 0);
    end
    finish_test();

    start_test("load_extend");  // one copied line, one untouched line
    for (int b = 0; b < 2; b++) begin
      base = (b == 0) ? 8 : 32'h140;
      for (int k = 0; k < LINE_BYTES; k++) begin
        core_access(rd_lb, wr_none, base + k, 0);
        core_access(rd_lbu, wr_none, base + k, 0);
        if (k % 2 == 0) begin
          core_access(rd_lh, wr_none, base + k, 0);
          core_access(rd_lhu, wr_none, base + k, 0);
        end
      end
    end
    finish_test();

    start_test("store_merge");
    store_and_check_line(wr_sb, 32'h183, 32'h0000_0080);
    store_and_check_line(wr_sh, 32'h186, 32'h0000_9A5C);
    store_and_check_line(wr_sw, 32'h180, 32'hC0DE_F00D);
    store_and_check_line(wr_sb, 32'h015, 32'h0000_00E7);  // inside the copied image
    store_and_check_line(wr_sh, 32'h03A, 32'h0000_1234);
    finish_test();

    start_test("random");
    for (int n = 0; n < 48; n++) begin
      op = rand_bits(3);
      a  = rand_bits(10);  // low 1 KB
      d  = rand_bits(32);
      case (op)
        0:       core_access(rd_lb, wr_none, a, 0);
        1:       core_access(rd_lbu, wr_none, a, 0);
        2:       core_access(rd_lh, wr_none, a & ~1, 0);
        3:       core_access(rd_lhu, wr_none, a & ~1, 0);
        4:       core_access(rd_lw, wr_none, a & ~3, 0);
        5:       core_access(rd_none, wr_sb, a, d);
        6:       core_access(rd_none, wr_sh, a & ~1, d);
        default: core_access(rd_none, wr_sw, a & ~3, d);
      endcase
    end
    finish_test();

    end_run();
  end

endmodule

/* vlog.f */
design/soc_cfg_pkg.sv
design/mem_types_pkg.sv
design/flash_loader.sv
design/ramio_port.sv
design/burst_arbiter.sv
design/mem_top.sv
verif/tb_models.sv
verif/mem_top_tb.sv

/* Makefile */
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= mem_top_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

PASS_MSG := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, fail unless the run passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
